/* build.f */
+incdir+hdl
hdl/wb_pkg.sv
hdl/wb_stage_reg.sv
hdl/trap_priority.sv
hdl/wb_writeback.sv
hdl/wb_stage.sv
testbench/tb_wb_stage.sv

/* hdl/trap_priority.sv */
`timescale 1ns/100ps

`include "wb_settings.svh"

module trap_priority import wb_pkg::*; (
    input  wb_bundle_t wb_i,
    input  logic       lsu_misaligned_i,
    input  logic       lsu_ld_err_i,
    input  logic       lsu_st_err_i,
    input  logic       csr_exception_i,
    input  logic       xint_pending_i,
    input  xcause_e    xint_xcause_i,
    output trap_t      trap_o,
    output logic       xret_o
);

    logic [11:0] funct12;
    logic        valid;
    logic        xint;
    logic        ex_exc;
    logic        misal;
    logic        ld_err;
    logic        st_err;
    logic        csr_ill;
    logic        xcall;
    logic        xbreak;
    logic        is_xret;
    logic        sync_exc;

    // --------------------
    // Source decode
    // --------------------
    assign funct12 = {wb_i.ex.instr.sys_view.funct7, wb_i.ex.instr.sys_view.rs2};
    assign valid   = !wb_i.bubble;                  // Bubble masks everything

    assign xint    = xint_pending_i && valid;
    assign ex_exc  = wb_i.ex.exception && valid;
    assign misal   = lsu_misaligned_i && valid;
    assign ld_err  = lsu_ld_err_i && valid;
    assign st_err  = lsu_st_err_i && valid;
    assign csr_ill = csr_exception_i && valid;

    assign xcall   = wb_i.ex.ctrl.ecall_break && valid && (funct12 == `WB_FUNCT12_ECALL);
    assign xbreak  = wb_i.ex.ctrl.ecall_break && valid && (funct12 == `WB_FUNCT12_EBREAK);
    assign is_xret = wb_i.ex.ctrl.ecall_break && valid &&
                     (wb_i.ex.instr.sys_view.rs2 == `WB_XRET_RS2);

    assign sync_exc = ex_exc | misal | ld_err | st_err | csr_ill | xcall | xbreak;

    // A faulting instruction does not return; an interrupt may still land on it
    assign xret_o = is_xret && !sync_exc;

    // --------------------
    // Fixed priority encode
    // --------------------
    always_comb begin
        trap_o.exception = xint | sync_exc;
        trap_o.epc       = wb_i.ex.pc;
        trap_o.xcause    = E_INST_MISALIGNED;
        trap_o.mtval     = '0;
        if (xint) begin
            trap_o.xcause = xint_xcause_i;
        end else if (ex_exc) begin                   // Fetch or decode fault
            trap_o.xcause = wb_i.ex.xcause;
            trap_o.mtval  = wb_i.ex.mtval;
        end else if (misal) begin
            if (wb_i.ex.instr.i_view.opcode[`WB_OPC_STORE_BIT]) begin
                trap_o.xcause = E_STORE_MISALIGNED;
            end else begin
                trap_o.xcause = E_LOAD_MISALIGNED;
            end
            trap_o.mtval = wb_i.ex.alu_result;       // Faulting address
        end else if (ld_err) begin
            trap_o.xcause = E_LOAD_ACCESS_FAULT;
            trap_o.mtval  = wb_i.ex.alu_result;
        end else if (st_err) begin
            trap_o.xcause = E_STORE_ACCESS_FAULT;
            trap_o.mtval  = wb_i.ex.alu_result;
        end else if (csr_ill) begin
            trap_o.xcause = E_ILLEGAL_INST;
            trap_o.mtval  = wb_i.ex.instr;           // Offending word
        end else if (xcall) begin
            trap_o.xcause = E_ECALL_FROM_M;
        end else if (xbreak) begin
            trap_o.xcause = E_BREAKPOINT;
            trap_o.mtval  = wb_i.ex.pc;
        end
    end

    // --------------------
    // Checks
    // --------------------
    always_comb begin
        if (trap_o.exception) begin
            a_cause_known: assert final (!$isunknown(trap_o.xcause));
        end
        if (!xint_pending_i) begin
            a_xret_no_trap: assert final (!(xret_o && trap_o.exception));
        end
    end

endmodule

/* hdl/wb_pkg.sv */
`include "wb_settings.svh"

package wb_pkg;

    // --------------------
    // Encodings
    // --------------------
    typedef enum logic [1:0] {
        WB_SEL_ALU = 2'd0,
        WB_SEL_LSU = 2'd1,
        WB_SEL_CSR = 2'd2,
        WB_SEL_PC4 = 2'd3
    } wb_sel_e;

    typedef enum logic [`WB_CAUSE_W-1:0] {
        E_INST_MISALIGNED    = 4'd0,
        E_INST_ACCESS_FAULT  = 4'd1,
        E_ILLEGAL_INST       = 4'd2,
        E_BREAKPOINT         = 4'd3,
        E_LOAD_MISALIGNED    = 4'd4,
        E_LOAD_ACCESS_FAULT  = 4'd5,
        E_STORE_MISALIGNED   = 4'd6,
        E_STORE_ACCESS_FAULT = 4'd7,
        E_ECALL_FROM_M       = 4'd11
    } xcause_e;

    // --------------------
    // Control and instruction
    // --------------------
    typedef struct packed {
        logic                     rf_we;
        logic                     mem_en;
        logic                     mem_rw;       // High for store
        logic [`WB_CSR_CMD_W-1:0] csr_cmd;
        wb_sel_e                  sel_wb;
        logic                     ecall_break;  // SYSTEM opcode with funct3 0
    } ctrl_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_view_t;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } sys_view_t;

    // Same word, I-type fields or SYSTEM fields
    typedef union packed {
        i_view_t   i_view;
        sys_view_t sys_view;
    } instr_u;

    // --------------------
    // Stage bundles
    // --------------------
    typedef struct packed {
        logic [`WB_XLEN-1:0] pc;
        logic [`WB_XLEN-1:0] pc4;
        instr_u              instr;
        logic [`WB_XLEN-1:0] alu_result;   // Also the load/store address
        logic [`WB_XLEN-1:0] lsu_wdata;
        ctrl_t               ctrl;
        logic                exception;    // Raised by an earlier stage
        xcause_e             xcause;
        logic [`WB_XLEN-1:0] mtval;
    } ex_result_t;

    typedef struct packed {
        ex_result_t ex;
        logic       bubble;
    } wb_bundle_t;

    typedef struct packed {
        logic                exception;
        xcause_e             xcause;
        logic [`WB_XLEN-1:0] mtval;
        logic [`WB_XLEN-1:0] epc;
    } trap_t;

    typedef struct packed {
        logic                 wen;
        logic [`WB_REG_W-1:0] waddr;
        logic [`WB_XLEN-1:0]  wdata;
    } rf_write_t;

    typedef struct packed {
        logic [`WB_CSR_ADDR_W-1:0] addr;
        logic [`WB_CSR_CMD_W-1:0]  cmd;
        logic                      rs1_zero;
        logic [`WB_XLEN-1:0]       wdata;
    } csr_req_t;

endpackage

/* hdl/wb_settings.svh */
`ifndef WB_SETTINGS_SVH
`define WB_SETTINGS_SVH

// Widths
`define WB_XLEN          32
`define WB_REG_W         5
`define WB_CAUSE_W       4
`define WB_CSR_ADDR_W    12
`define WB_CSR_CMD_W     3
`define WB_LSU_SIZE_W    2

// Instruction field positions and codes
`define WB_OPC_STORE_BIT   5        // Opcode bit 5 splits store from load
`define WB_F3_ZIMM_BIT     2        // CSR immediate form
`define WB_F3_USIGN_BIT    2        // Unsigned load
`define WB_XRET_RS2        5'd2
`define WB_FUNCT12_ECALL   12'h000
`define WB_FUNCT12_EBREAK  12'h001

`endif

/* hdl/wb_stage.sv */
`timescale 1ns/100ps

`include "wb_settings.svh"

module wb_stage import wb_pkg::*; (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  ex_result_t                ex_result_i,
    input  logic                      exwb_enable_i,
    input  logic                      exwb_clear_i,
    input  logic [`WB_XLEN-1:0]       lsu_rdata_i,
    input  logic                      lsu_misaligned_i,
    input  logic                      lsu_ld_err_i,
    input  logic                      lsu_st_err_i,
    input  logic [`WB_XLEN-1:0]       csr_rdata_i,
    input  logic                      csr_exception_i,
    input  logic                      xint_pending_i,
    input  xcause_e                   xint_xcause_i,
    output rf_write_t                 rf_write_o,
    output trap_t                     trap_o,
    output logic                      xret_o,
    output csr_req_t                  csr_req_o,
    output logic [`WB_XLEN-1:0]       lsu_addr_o,
    output logic [`WB_XLEN-1:0]       lsu_wdata_o,
    output logic                      lsu_en_o,
    output logic                      lsu_we_o,
    output logic [`WB_LSU_SIZE_W-1:0] lsu_size_o,
    output logic                      lsu_sign_ext_o
);

    wb_bundle_t wb;     // Registered EX/WB content

    wb_stage_reg u_stage_reg (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .ex_result_i   (ex_result_i),
        .exwb_enable_i (exwb_enable_i),
        .exwb_clear_i  (exwb_clear_i),
        .wb_o          (wb)
    );

    trap_priority u_trap (
        .wb_i             (wb),
        .lsu_misaligned_i (lsu_misaligned_i),
        .lsu_ld_err_i     (lsu_ld_err_i),
        .lsu_st_err_i     (lsu_st_err_i),
        .csr_exception_i  (csr_exception_i),
        .xint_pending_i   (xint_pending_i),
        .xint_xcause_i    (xint_xcause_i),
        .trap_o           (trap_o),
        .xret_o           (xret_o)
    );

    wb_writeback u_writeback (
        .wb_i             (wb),
        .trap_exception_i (trap_o.exception),
        .lsu_rdata_i      (lsu_rdata_i),
        .csr_rdata_i      (csr_rdata_i),
        .rf_write_o       (rf_write_o),
        .csr_req_o        (csr_req_o),
        .lsu_addr_o       (lsu_addr_o),
        .lsu_wdata_o      (lsu_wdata_o),
        .lsu_en_o         (lsu_en_o),
        .lsu_we_o         (lsu_we_o),
        .lsu_size_o       (lsu_size_o),
        .lsu_sign_ext_o   (lsu_sign_ext_o)
    );

endmodule

/* hdl/wb_stage_reg.sv */
`timescale 1ns/100ps

module wb_stage_reg import wb_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_i,
    input  ex_result_t ex_result_i,
    input  logic       exwb_enable_i,
    input  logic       exwb_clear_i,
    output wb_bundle_t wb_o
);

    ex_result_t payload_q;     // Data part of the bundle
    ctrl_t      ctrl_q;
    logic       exception_q;
    logic       bubble_q;

    // --------------------
    // Control part
    // --------------------
    always_ff @(posedge clk_i) begin
        if (rst_i || exwb_clear_i) begin       // Clear beats enable
            ctrl_q      <= '0;
            exception_q <= 1'b0;
            bubble_q    <= 1'b1;
        end else if (exwb_enable_i) begin
            ctrl_q      <= ex_result_i.ctrl;
            exception_q <= ex_result_i.exception;
            bubble_q    <= 1'b0;
        end
    end

    // Data part, don't care while bubble is set
    always_ff @(posedge clk_i) begin
        if (exwb_enable_i) begin
            payload_q <= ex_result_i;
        end
    end

    always_comb begin
        wb_o              = '0;
        wb_o.ex           = payload_q;
        wb_o.ex.ctrl      = ctrl_q;       // Control fields come from the reset flops
        wb_o.ex.exception = exception_q;
        wb_o.bubble       = bubble_q;
    end

    // --------------------
    // Checks
    // --------------------
    a_clear_bubble: assert property (@(posedge clk_i) disable iff (rst_i)
        exwb_clear_i |=> wb_o.bubble);

endmodule

/* hdl/wb_writeback.sv */
`timescale 1ns/100ps

`include "wb_settings.svh"

module wb_writeback import wb_pkg::*; (
    input  wb_bundle_t                wb_i,
    input  logic                      trap_exception_i,
    input  logic [`WB_XLEN-1:0]       lsu_rdata_i,
    input  logic [`WB_XLEN-1:0]       csr_rdata_i,
    output rf_write_t                 rf_write_o,
    output csr_req_t                  csr_req_o,
    output logic [`WB_XLEN-1:0]       lsu_addr_o,
    output logic [`WB_XLEN-1:0]       lsu_wdata_o,
    output logic                      lsu_en_o,
    output logic                      lsu_we_o,
    output logic [`WB_LSU_SIZE_W-1:0] lsu_size_o,
    output logic                      lsu_sign_ext_o
);

    logic               valid;
    logic               cmd_ok;
    logic [`WB_XLEN-1:0] rf_wdata;
    i_view_t            iv;

    assign iv    = wb_i.ex.instr.i_view;
    assign valid = !wb_i.bubble;

    // LSU and CSR file see their own faults, so only the upstream fault gates them
    assign cmd_ok = valid && !wb_i.ex.exception;

    // --------------------
    // Register file write
    // --------------------
    always_comb begin
        rf_wdata = wb_i.ex.alu_result;
        case (wb_i.ex.ctrl.sel_wb)
            WB_SEL_ALU: rf_wdata = wb_i.ex.alu_result;
            WB_SEL_LSU: rf_wdata = lsu_rdata_i;
            WB_SEL_CSR: rf_wdata = csr_rdata_i;   // Old CSR value
            WB_SEL_PC4: rf_wdata = wb_i.ex.pc4;   // Link address
        endcase
    end

    assign rf_write_o.wen   = wb_i.ex.ctrl.rf_we && valid && !trap_exception_i;
    assign rf_write_o.waddr = iv.rd;
    assign rf_write_o.wdata = rf_wdata;

    // --------------------
    // CSR request
    // --------------------
    assign csr_req_o.addr     = iv.imm12;
    assign csr_req_o.cmd      = cmd_ok ? wb_i.ex.ctrl.csr_cmd : '0;
    assign csr_req_o.rs1_zero = (iv.rs1 == '0);
    assign csr_req_o.wdata    = iv.funct3[`WB_F3_ZIMM_BIT] ?
                                {{(`WB_XLEN-`WB_REG_W){1'b0}}, iv.rs1} :   // zimm
                                wb_i.ex.alu_result;

    // LSU request
    assign lsu_addr_o     = wb_i.ex.alu_result;
    assign lsu_wdata_o    = wb_i.ex.lsu_wdata;
    assign lsu_en_o       = wb_i.ex.ctrl.mem_en && cmd_ok;
    assign lsu_we_o       = wb_i.ex.ctrl.mem_rw;
    assign lsu_size_o     = iv.funct3[`WB_LSU_SIZE_W-1:0];      // Byte, half, word
    assign lsu_sign_ext_o = !iv.funct3[`WB_F3_USIGN_BIT];

    // --------------------
    // Checks
    // --------------------
    always_comb begin
        if (trap_exception_i) begin
            a_no_write_on_trap: assert final (!rf_write_o.wen);
        end
    end

endmodule

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_wb_stage -f build.f \
    > build.log 2>&1 && ./obj_dir/Vtb_wb_stage > sim.log 2>&1
grep -q "^Done: no errors" sim.log 2>/dev/null && echo "PASS" || { echo "FAIL"; exit 1; }

/* testbench/tb_wb_stage.sv */
`timescale 1ns/100ps

`include "wb_settings.svh"

module tb_wb_stage import wb_pkg::*; ();

    localparam int CLK_PERIOD = 10;
    localparam int NUM_STEPS  = 200;
    localparam int TIMEOUT_NS = (NUM_STEPS + 50) * CLK_PERIOD + 100;

    logic clk_i;
    logic rst_i;
    ex_result_t ex_result_i;
    logic exwb_enable_i;
    logic exwb_clear_i;
    logic [`WB_XLEN-1:0] lsu_rdata_i;
    logic [`WB_XLEN-1:0] csr_rdata_i;
    logic lsu_misaligned_i;
    logic lsu_ld_err_i;
    logic lsu_st_err_i;
    logic csr_exception_i;
    logic xint_pending_i;
    xcause_e xint_xcause_i;
    rf_write_t rf_write_o;
    trap_t trap_o;
    logic xret_o;
    csr_req_t csr_req_o;
    logic [`WB_XLEN-1:0] lsu_addr_o;
    logic [`WB_XLEN-1:0] lsu_wdata_o;
    logic lsu_en_o;
    logic lsu_we_o;
    logic [`WB_LSU_SIZE_W-1:0] lsu_size_o;
    logic lsu_sign_ext_o;

    logic [31:0] rng_state;
    logic hold_phase;           // Inputs frozen, register must hold
    ex_result_t mdl_ex;         // Last enabled bundle
    logic mdl_bubble;
    logic seen_enable;
    trap_t exp_trap;
    trap_t exp_sync;            // Same rules without the interrupt
    rf_write_t exp_rf;
    csr_req_t exp_csr;
    logic exp_xret;
    logic [68:0] exp_lsu;
    logic [68:0] lsu_bus;

    wb_stage UUT (.*);

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    task automatic report_failure(input string line);
        $display("%s", line);
        $display("Done: errors found");
        $fatal(1, "simulation stopped at the first error");
    endtask

    initial begin
        #(TIMEOUT_NS);
        report_failure($sformatf("The run timed out after %0d ns", TIMEOUT_NS));
    end

    // --------------------
    // Random stimulus
    // --------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic xcause_e pick_cause(input logic [2:0] sel);
        case (sel)
            3'd0: return E_INST_MISALIGNED;
            3'd1: return E_INST_ACCESS_FAULT;
            3'd2: return E_ILLEGAL_INST;
            3'd3: return E_BREAKPOINT;
            3'd4: return E_LOAD_MISALIGNED;
            3'd5: return E_LOAD_ACCESS_FAULT;
            3'd6: return E_STORE_ACCESS_FAULT;
            default: return E_ECALL_FROM_M;
        endcase
    endfunction

    function automatic ex_result_t random_bundle();
        ex_result_t ex;
        logic [31:0] r;
        logic [31:0] w;
        r = next_rand();
        ex.pc  = {r[31:2], 2'b00};
        ex.pc4 = ex.pc + 32'd4;
        r = next_rand();
        case (r[2:0])
            3'd0: w = 32'h0000_0073;    // ecall
            3'd1: w = 32'h0010_0073;    // ebreak
            3'd2: w = 32'h3020_0073;    // mret
            default: w = next_rand();
        endcase
        ex.instr = w;
        r = next_rand();
        ex.ctrl = r[$bits(ctrl_t)-1:0];
        ex.ctrl.ecall_break = (w[6:0] == 7'h73) && (w[14:12] == 3'd0);
        ex.alu_result = next_rand();
        ex.lsu_wdata  = next_rand();
        r = next_rand();
        ex.exception = (r[3:0] == 4'd0);
        ex.xcause    = pick_cause(r[6:4]);
        ex.mtval     = next_rand();
        return ex;
    endfunction

    // Fault flags at 1 in 8, so several often arrive together
    task automatic drive_side(input logic force_int);
        logic [31:0] r;
        r = next_rand();
        lsu_misaligned_i = (r[2:0] == 3'd0);
        lsu_ld_err_i     = (r[5:3] == 3'd0);
        lsu_st_err_i     = (r[8:6] == 3'd0);
        csr_exception_i  = (r[11:9] == 3'd0);
        xint_pending_i   = force_int || (r[15:12] == 4'd0);
        xint_xcause_i    = pick_cause(r[18:16]);
        lsu_rdata_i      = next_rand();
        csr_rdata_i      = next_rand();
    endtask

    // --------------------
    // Reference model
    // --------------------
    always @(posedge clk_i) begin
        if (rst_i || exwb_clear_i) begin
            mdl_bubble <= 1'b1;
        end else if (exwb_enable_i) begin
            mdl_bubble <= 1'b0;
        end
        if (exwb_enable_i) begin
            mdl_ex <= ex_result_i;
        end
        seen_enable <= rst_i ? 1'b0 : (seen_enable || exwb_enable_i);
    end

    function automatic trap_t expect_trap(input ex_result_t ex, input logic bubble,
                                          input logic xint, input xcause_e xint_cause);
        trap_t t;
        logic [31:0] w;
        w = ex.instr;
        t.exception = 1'b1;
        t.xcause    = E_INST_MISALIGNED;
        t.mtval     = '0;
        t.epc       = ex.pc;
        if (bubble) t.exception = 1'b0;
        else if (xint) t.xcause = xint_cause;
        else if (ex.exception) begin
            t.xcause = ex.xcause;
            t.mtval  = ex.mtval;
        end else if (lsu_misaligned_i) begin
            t.xcause = w[5] ? E_STORE_MISALIGNED : E_LOAD_MISALIGNED;
            t.mtval  = ex.alu_result;
        end else if (lsu_ld_err_i) begin
            t.xcause = E_LOAD_ACCESS_FAULT;
            t.mtval  = ex.alu_result;
        end else if (lsu_st_err_i) begin
            t.xcause = E_STORE_ACCESS_FAULT;
            t.mtval  = ex.alu_result;
        end else if (csr_exception_i) begin
            t.xcause = E_ILLEGAL_INST;
            t.mtval  = w;
        end else if (ex.ctrl.ecall_break && w[31:20] == 12'h000) t.xcause = E_ECALL_FROM_M;
        else if (ex.ctrl.ecall_break && w[31:20] == 12'h001) begin
            t.xcause = E_BREAKPOINT;
            t.mtval  = ex.pc;
        end else t.exception = 1'b0;
        return t;
    endfunction

    always_comb begin
        logic [31:0] w;
        w = mdl_ex.instr;
        exp_trap = expect_trap(mdl_ex, mdl_bubble, xint_pending_i, xint_xcause_i);
        exp_sync = expect_trap(mdl_ex, mdl_bubble, 1'b0, xint_xcause_i);
        exp_rf.waddr = w[11:7];
        case (mdl_ex.ctrl.sel_wb)
            WB_SEL_ALU: exp_rf.wdata = mdl_ex.alu_result;
            WB_SEL_LSU: exp_rf.wdata = lsu_rdata_i;
            WB_SEL_CSR: exp_rf.wdata = csr_rdata_i;
            default:    exp_rf.wdata = mdl_ex.pc4;
        endcase
        exp_rf.wen = mdl_bubble ? 1'b0 : (mdl_ex.ctrl.rf_we && !exp_trap.exception);
        exp_csr.addr     = w[31:20];
        exp_csr.cmd      = (mdl_bubble || mdl_ex.exception) ? '0 : mdl_ex.ctrl.csr_cmd;
        exp_csr.rs1_zero = (w[19:15] == 5'd0);
        exp_csr.wdata    = w[14] ? {27'd0, w[19:15]} : mdl_ex.alu_result;
        exp_xret = mdl_bubble ? 1'b0 :
                   (mdl_ex.ctrl.ecall_break && w[24:20] == 5'd2 && !exp_sync.exception);
        exp_lsu = {mdl_ex.alu_result, mdl_ex.lsu_wdata,
                   (mdl_bubble || mdl_ex.exception) ? 1'b0 : mdl_ex.ctrl.mem_en,
                   mdl_ex.ctrl.mem_rw, w[13:12], !w[14]};
    end

    assign lsu_bus = {lsu_addr_o, lsu_wdata_o, lsu_en_o, lsu_we_o, lsu_size_o, lsu_sign_ext_o};

    // --------------------
    // Checks
    // --------------------
    a_reset_idle: assert property (@(posedge clk_i) disable iff (rst_i)
        !seen_enable |-> !rf_write_o.wen && !trap_o.exception && !xret_o && !lsu_en_o)
        else report_failure($sformatf("mismatch at %0t: outputs active before any capture", $time));
    a_trap: assert property (@(posedge clk_i) disable iff (rst_i)
        trap_o.exception == exp_trap.exception && (!exp_trap.exception || trap_o == exp_trap))
        else report_failure($sformatf("mismatch at %0t: trap_o %h, expected %h",
                                      $time, trap_o, exp_trap));
    a_rf_write: assert property (@(posedge clk_i) disable iff (rst_i)
        rf_write_o.wen == exp_rf.wen && (mdl_bubble || rf_write_o == exp_rf))
        else report_failure($sformatf("mismatch at %0t: rf_write_o %h, expected %h",
                                      $time, rf_write_o, exp_rf));
    a_xret: assert property (@(posedge clk_i) disable iff (rst_i) xret_o == exp_xret)
        else report_failure($sformatf("mismatch at %0t: xret_o %b, expected %b",
                                      $time, xret_o, exp_xret));
    a_csr_req: assert property (@(posedge clk_i) disable iff (rst_i)
        csr_req_o.cmd == exp_csr.cmd && (mdl_bubble || csr_req_o == exp_csr))
        else report_failure($sformatf("mismatch at %0t: csr_req_o %h, expected %h",
                                      $time, csr_req_o, exp_csr));
    a_lsu_req: assert property (@(posedge clk_i) disable iff (rst_i)
        lsu_en_o == exp_lsu[4] && (mdl_bubble || lsu_bus == exp_lsu))
        else report_failure($sformatf("mismatch at %0t: lsu request %h, expected %h",
                                      $time, lsu_bus, exp_lsu));
    a_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        hold_phase |-> rf_write_o == $past(rf_write_o) && trap_o == $past(trap_o) &&
                       xret_o == $past(xret_o) && csr_req_o == $past(csr_req_o) &&
                       lsu_bus == $past(lsu_bus))
        else report_failure($sformatf("mismatch at %0t: outputs moved while stalled", $time));

    initial begin
        int hold_left;
        logic force_int;
        logic [31:0] r;
        rng_state = 32'h919f4d17;
        rst_i = 1'b1;
        exwb_enable_i = 1'b0;
        exwb_clear_i = 1'b0;
        ex_result_i = '0;
        hold_phase = 1'b0;
        hold_left = 0;
        force_int = 1'b0;
        drive_side(1'b0);
        repeat (2) @(posedge clk_i);
        #1 rst_i = 1'b0;
        repeat (2) @(posedge clk_i);    // Idle bubble after reset
        for (int i = 0; i < NUM_STEPS; i++) begin
            @(posedge clk_i);
            #1;
            if (hold_left > 0) begin
                hold_left--;
                hold_phase = 1'b1;
                ex_result_i = random_bundle();  // Must not get in
            end else begin
                hold_phase = 1'b0;
                drive_side(force_int);
                force_int = 1'b0;
                r = next_rand();
                exwb_clear_i = (r[3:0] == 4'd0);
                exwb_enable_i = exwb_clear_i ? r[4] : (r[3:0] != 4'd1);
                ex_result_i = random_bundle();
                if (exwb_clear_i) force_int = 1'b1;     // Interrupt lands on the bubble
                if (r[3:0] == 4'd1) hold_left = 3;
            end
        end
        @(posedge clk_i);
        #1;
        exwb_enable_i = 1'b0;
        exwb_clear_i = 1'b0;
        hold_phase = 1'b0;
        repeat (2) @(posedge clk_i);
        $display("Done: no errors");
        $finish;
    end

endmodule
